// File: fetch_top.f
+incdir+hdl
hdl/axi_rd_pkg.sv
hdl/blk_pkg.sv
hdl/raddr_channel.sv
hdl/rdata_router.sv
hdl/quant_lane.sv
hdl/result_collector.sv
hdl/fetch_top.sv
sim/axi_rd_mem_model.sv
sim/fetch_tb.sv

// File: hdl/axi_rd_pkg.sv
//------------------------------------------------
// AXI read channel types
//------------------------------------------------
package axi_rd_pkg;

    localparam int AXI_ADDR_W = 64;
    localparam int AXI_DATA_W = 64;
    localparam int AXI_LEN_W  = 8;

    typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
    typedef logic [AXI_LEN_W-1:0]  axi_len_t;

    // Eight pixels, byte 0 lowest
    typedef logic [7:0][7:0] pix_vec_t;

    // Four scale entries, entry 0 lowest
    typedef logic [3:0][15:0] scl_vec_t;

    // One R data word, seen as pixels or as table entries
    typedef union packed {
        pix_vec_t pix;
        scl_vec_t scale;
    } rd_beat_t;

endpackage

// File: hdl/blk_pkg.sv
//------------------------------------------------
// Block and lane types
//------------------------------------------------
`include "fetch_settings.svh"

package blk_pkg;

    localparam int LANE_SEL_W = (`FETCH_NUM_LANES > 1) ? $clog2(`FETCH_NUM_LANES) : 1;

    typedef logic [15:0] scale_t;
    typedef logic [10:0] pix_sum_t;
    typedef logic [31:0] acc_t;
    typedef logic [23:0] result_t;

    // Block grid size minus one
    typedef logic [9:0] blk_dim_t;

    typedef logic [LANE_SEL_W-1:0] lane_sel_t;

endpackage

// File: hdl/fetch_settings.svh
//------------------------------------------------
// Block fetch engine settings
//------------------------------------------------
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// Number of quantizer lanes (1, 2, 4 or 8)
`define FETCH_NUM_LANES    4

// Burst shapes
`define FETCH_DQM_BEATS    6
`define FETCH_BLK_BEATS    3
`define FETCH_BLK_STRIDE   384

// Scale table use
`define FETCH_SCALE_SETS   8
`define FETCH_SCALE_SHIFT  8

`endif

// File: hdl/fetch_top.sv
//------------------------------------------------
// Block fetch engine top
//------------------------------------------------
`timescale 1ns/100ps
`include "fetch_settings.svh"

module fetch_top
    import axi_rd_pkg::*;
    import blk_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    output axi_addr_t             m_axi_araddr,
    output axi_len_t              m_axi_arlen,
    output logic                  m_axi_arvalid,
    input  logic                  m_axi_arready,
    input  logic [AXI_DATA_W-1:0] m_axi_rdata,
    input  logic                  m_axi_rvalid,
    output logic                  m_axi_rready,
    input  logic                  m_axi_rlast,
    input  logic                  start_pulse,
    input  axi_addr_t             source_address,
    input  axi_addr_t             dqm_address,
    input  blk_dim_t              w1,
    input  blk_dim_t              h1,
    output result_t               out_result,
    output logic                  out_req,
    input  logic                  out_ack
);

    logic                                r_burst_done;
    logic    [`FETCH_NUM_LANES-1:0]      lane_req;
    logic    [`FETCH_NUM_LANES-1:0]      lane_ack;
    pix_vec_t                            lane_beat;
    scale_t                              lane_scale;
    logic                                lane_last;
    logic    [`FETCH_NUM_LANES-1:0]      res_req;
    logic    [`FETCH_NUM_LANES-1:0]      res_ack;
    result_t [`FETCH_NUM_LANES-1:0]      res_data;

    raddr_channel i_raddr (
        .clk, .rst_n, .start_pulse, .source_address, .dqm_address, .w1, .h1,
        .m_axi_araddr, .m_axi_arlen, .m_axi_arvalid, .m_axi_arready, .r_burst_done
    );

    rdata_router i_router (
        .clk, .rst_n, .start_pulse, .m_axi_rdata, .m_axi_rvalid, .m_axi_rlast,
        .m_axi_rready, .r_burst_done, .lane_req, .lane_beat, .lane_scale,
        .lane_last, .lane_ack
    );

    //------------------------------------------------
    // Quantizer lanes
    //------------------------------------------------
    for (genvar i = 0; i < `FETCH_NUM_LANES; i++) begin : g_lane
        quant_lane i_lane (
            .clk, .rst_n,
            .lane_req   (lane_req[i]),
            .lane_beat,
            .lane_scale,
            .lane_last,
            .lane_ack   (lane_ack[i]),
            .res_req    (res_req[i]),
            .res_data   (res_data[i]),
            .res_ack    (res_ack[i])
        );
    end

    result_collector i_collect (
        .clk, .rst_n, .start_pulse, .res_req, .res_data, .res_ack,
        .out_req, .out_result, .out_ack
    );

endmodule

// File: hdl/quant_lane.sv
//------------------------------------------------
// Quantizer lane
//------------------------------------------------
`timescale 1ns/100ps
`include "fetch_settings.svh"

module quant_lane
    import axi_rd_pkg::*;
    import blk_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     lane_req,
    input  pix_vec_t lane_beat,
    input  scale_t   lane_scale,
    input  logic     lane_last,
    output logic     lane_ack,
    output logic     res_req,
    output result_t  res_data,
    input  logic     res_ack
);

    pix_sum_t pix_sum;
    acc_t     prod;
    acc_t     acc_q;
    logic     fin_q;
    logic     hold;

    always_comb begin
        pix_sum = '0;
        for (int i = 0; i < 8; i++) begin
            pix_sum = pix_sum + pix_sum_t'(lane_beat[i]);
        end
    end

    assign prod = acc_t'(pix_sum) * acc_t'(lane_scale);
    // Busy until the collector has fully taken the last result
    assign hold = fin_q || res_req || res_ack;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lane_ack <= 1'b0;
            acc_q    <= '0;
            fin_q    <= 1'b0;
            res_req  <= 1'b0;
        end else begin
            if (lane_req && !lane_ack && !hold) begin
                lane_ack <= 1'b1;
                acc_q    <= acc_q + prod;
                fin_q    <= lane_last;
            end else if (lane_ack && !lane_req) begin
                lane_ack <= 1'b0;
            end
            if (fin_q) begin
                res_req <= 1'b1;
                acc_q   <= '0;
                fin_q   <= 1'b0;
            end else if (res_req && res_ack) begin
                res_req <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fin_q) res_data <= result_t'(acc_q >> `FETCH_SCALE_SHIFT);
    end

endmodule

// File: hdl/raddr_channel.sv
//------------------------------------------------
// AXI read address sequencer
//------------------------------------------------
`timescale 1ns/100ps
`include "fetch_settings.svh"

module raddr_channel
    import axi_rd_pkg::*;
    import blk_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start_pulse,
    input  axi_addr_t source_address,
    input  axi_addr_t dqm_address,
    input  blk_dim_t  w1,
    input  blk_dim_t  h1,
    output axi_addr_t m_axi_araddr,
    output axi_len_t  m_axi_arlen,
    output logic      m_axi_arvalid,
    input  logic      m_axi_arready,
    input  logic      r_burst_done
);

    typedef enum logic [4:0] {
        IDLE     = 5'b00001,
        DQM_ADDR = 5'b00010,
        BLK_ADDR = 5'b00100,
        SEND     = 5'b01000,
        WAIT_R   = 5'b10000
    } state_t;

    state_t    state;
    state_t    state_nxt;
    axi_addr_t addr_q;
    axi_addr_t src_q;
    axi_len_t  len_q;
    blk_dim_t  x_q;
    blk_dim_t  y_q;
    blk_dim_t  w1_q;
    blk_dim_t  h1_q;
    logic      first_q;
    logic      last_q;

    assign m_axi_araddr  = addr_q;
    assign m_axi_arlen   = len_q;
    assign m_axi_arvalid = (state == SEND);

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:     if (start_pulse) state_nxt = DQM_ADDR;
            DQM_ADDR: state_nxt = SEND;
            BLK_ADDR: state_nxt = SEND;
            SEND:     if (m_axi_arready) state_nxt = WAIT_R;
            // Next address only once the whole burst is back
            WAIT_R:   if (r_burst_done) state_nxt = last_q ? IDLE : BLK_ADDR;
            default:  state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= IDLE;
            x_q     <= '0;
            y_q     <= '0;
            first_q <= 1'b0;
            last_q  <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == IDLE && start_pulse) begin
                x_q     <= '0;
                y_q     <= '0;
                first_q <= 1'b1;
                last_q  <= 1'b0;
            end
            if (state == BLK_ADDR) begin
                first_q <= 1'b0;
                last_q  <= (x_q == w1_q) && (y_q == h1_q);
                if (x_q == w1_q) begin
                    x_q <= '0;
                    y_q <= y_q + 1'b1;
                end else begin
                    x_q <= x_q + 1'b1;
                end
            end
        end
    end

    // Sizes and base are taken at start
    always_ff @(posedge clk) begin
        if (state == IDLE && start_pulse) begin
            src_q <= source_address;
            w1_q  <= w1;
            h1_q  <= h1;
        end
        if (state == DQM_ADDR) begin
            addr_q <= dqm_address;
            len_q  <= axi_len_t'(`FETCH_DQM_BEATS - 1);
        end
        if (state == BLK_ADDR) begin
            addr_q <= first_q ? src_q : addr_q + axi_addr_t'(`FETCH_BLK_STRIDE);
            len_q  <= axi_len_t'(`FETCH_BLK_BEATS - 1);
        end
    end

endmodule

// File: hdl/rdata_router.sv
//------------------------------------------------
// R beat router and scale table
//------------------------------------------------
`timescale 1ns/100ps
`include "fetch_settings.svh"

module rdata_router
    import axi_rd_pkg::*;
    import blk_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start_pulse,
    input  logic [AXI_DATA_W-1:0]       m_axi_rdata,
    input  logic                        m_axi_rvalid,
    input  logic                        m_axi_rlast,
    output logic                        m_axi_rready,
    output logic                        r_burst_done,
    output logic [`FETCH_NUM_LANES-1:0] lane_req,
    output pix_vec_t                    lane_beat,
    output scale_t                      lane_scale,
    output logic                        lane_last,
    input  logic [`FETCH_NUM_LANES-1:0] lane_ack
);

    localparam int NL          = `FETCH_NUM_LANES;
    localparam int TBL_ENTRIES = `FETCH_DQM_BEATS * 4;
    localparam int TBL_W       = $clog2(TBL_ENTRIES);
    localparam int TCNT_W      = $clog2(`FETCH_DQM_BEATS + 1);
    localparam int COMP_W      = $clog2(`FETCH_BLK_BEATS);

    rd_beat_t          beat;
    scale_t            scale_tbl [TBL_ENTRIES];
    logic [TCNT_W-1:0] tbl_cnt;
    logic [COMP_W-1:0] comp_q;
    logic [19:0]       blk_idx;
    logic [TBL_W-1:0]  tbl_idx;
    lane_sel_t         lane_pick;
    lane_sel_t         sel_q;
    logic              run_q;
    logic              busy_q;
    logic              take;
    logic              in_table;

    assign beat         = m_axi_rdata;
    assign m_axi_rready = run_q && !busy_q;
    assign take         = m_axi_rvalid && m_axi_rready;
    assign r_burst_done = take && m_axi_rlast;
    assign in_table     = (tbl_cnt < TCNT_W'(`FETCH_DQM_BEATS));
    assign lane_pick    = lane_sel_t'(blk_idx % NL);
    // Entry (block mod sets) * 3 + component
    assign tbl_idx = TBL_W'((blk_idx % `FETCH_SCALE_SETS) * `FETCH_BLK_BEATS + comp_q);

    // Table load and lane payload
    always_ff @(posedge clk) begin
        if (take && in_table) begin
            for (int e = 0; e < 4; e++) begin
                scale_tbl[tbl_cnt * 4 + e] <= beat.scale[e];
            end
        end
        if (take && !in_table) begin
            lane_beat  <= beat.pix;
            lane_scale <= scale_tbl[tbl_idx];
            lane_last  <= (comp_q == COMP_W'(`FETCH_BLK_BEATS - 1));
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_q    <= 1'b0;
            busy_q   <= 1'b0;
            lane_req <= '0;
            tbl_cnt  <= '0;
            comp_q   <= '0;
            blk_idx  <= '0;
            sel_q    <= '0;
        end else begin
            if (start_pulse) begin
                run_q   <= 1'b1;
                tbl_cnt <= '0;
                comp_q  <= '0;
                blk_idx <= '0;
            end else if (take) begin
                if (in_table) begin
                    tbl_cnt <= tbl_cnt + 1'b1;
                end else begin
                    busy_q   <= 1'b1;
                    sel_q    <= lane_pick;
                    lane_req <= NL'(1) << lane_pick;
                    if (comp_q == COMP_W'(`FETCH_BLK_BEATS - 1)) begin
                        comp_q  <= '0;
                        blk_idx <= blk_idx + 1'b1;
                    end else begin
                        comp_q <= comp_q + 1'b1;
                    end
                end
            end
            // Four-phase with the selected lane
            if (busy_q) begin
                if (lane_req[sel_q] && lane_ack[sel_q]) begin
                    lane_req <= '0;
                end else if (!lane_req[sel_q] && !lane_ack[sel_q]) begin
                    busy_q <= 1'b0;
                end
            end
        end
    end

endmodule

// File: hdl/result_collector.sv
//------------------------------------------------
// Lane result collector
//------------------------------------------------
`timescale 1ns/100ps
`include "fetch_settings.svh"

module result_collector
    import blk_pkg::*;
(
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 start_pulse,
    input  logic    [`FETCH_NUM_LANES-1:0]       res_req,
    input  result_t [`FETCH_NUM_LANES-1:0]       res_data,
    output logic    [`FETCH_NUM_LANES-1:0]       res_ack,
    output logic                                 out_req,
    output result_t                              out_result,
    input  logic                                 out_ack
);

    localparam int NL = `FETCH_NUM_LANES;

    typedef enum logic [1:0] {C_WAIT, C_LACK, C_OREQ, C_ODONE} cstate_t;

    cstate_t   state;
    lane_sel_t ptr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= C_WAIT;
            ptr     <= '0;
            res_ack <= '0;
            out_req <= 1'b0;
        end else begin
            case (state)
                C_WAIT: if (res_req[ptr]) begin
                    res_ack[ptr] <= 1'b1;
                    state        <= C_LACK;
                end
                C_LACK: if (!res_req[ptr]) begin
                    res_ack[ptr] <= 1'b0;
                    out_req      <= 1'b1;
                    state        <= C_OREQ;
                end
                C_OREQ: if (out_ack) begin
                    out_req <= 1'b0;
                    state   <= C_ODONE;
                end
                C_ODONE: if (!out_ack) begin
                    // Next lane holds the next block
                    ptr   <= (ptr == lane_sel_t'(NL - 1)) ? '0 : ptr + 1'b1;
                    state <= C_WAIT;
                end
                default: state <= C_WAIT;
            endcase
            if (start_pulse) ptr <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (state == C_WAIT && res_req[ptr]) out_result <= res_data[ptr];
    end

endmodule

// File: sim/axi_rd_mem_model.sv
//------------------------------------------------
// AXI read slave memory model
//------------------------------------------------
`timescale 1ns/100ps

module axi_rd_mem_model (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [63:0] araddr,
    input  logic [7:0]  arlen,
    input  logic        arvalid,
    output logic        arready,
    output logic [63:0] rdata,
    output logic        rvalid,
    input  logic        rready,
    output logic        rlast,
    input  logic [3:0]  gap_odds
);

    logic [63:0] mem [4096];
    logic [11:0] word_idx;
    logic [63:0] addr_s;
    logic [7:0]  len_s;
    logic        ar_fire;
    logic        r_fire;
    int          beats_left;
    integer      seed;

    initial begin
        seed       = 32'h917e26fb;
        arready    = 1'b0;
        rvalid     = 1'b0;
        rlast      = 1'b0;
        rdata      = '0;
        word_idx   = '0;
        beats_left = 0;
    end

    // Handshakes seen at the rising edge, outputs changed on the falling edge
    always begin
        @(posedge clk);
        ar_fire = arvalid && arready;
        r_fire  = rvalid && rready;
        addr_s  = araddr;
        len_s   = arlen;
        @(negedge clk);
        if (!rst_n) begin
            arready    = 1'b0;
            rvalid     = 1'b0;
            rlast      = 1'b0;
            beats_left = 0;
        end else begin
            if (r_fire) begin
                rvalid     = 1'b0;
                rlast      = 1'b0;
                word_idx   = word_idx + 1'b1;
                beats_left = beats_left - 1;
            end
            if (ar_fire) begin
                word_idx   = addr_s[14:3];
                beats_left = len_s + 1;
            end
            arready = (beats_left == 0);
            // Gap odds out of 16 per cycle
            if (beats_left > 0 && !rvalid && (($random(seed) & 15) >= gap_odds)) begin
                rvalid = 1'b1;
                rdata  = mem[word_idx];
                rlast  = (beats_left == 1);
            end
        end
    end

endmodule

// File: sim/fetch_tb.sv
//------------------------------------------------
// Block fetch engine testbench
//------------------------------------------------
`timescale 1ns/100ps
`include "fetch_settings.svh"

module fetch_tb
    import axi_rd_pkg::*;
    import blk_pkg::*;
();

    logic        clk;
    logic        rst_n;
    logic        start_pulse;
    axi_addr_t   source_address;
    axi_addr_t   dqm_address;
    blk_dim_t    w1;
    blk_dim_t    h1;
    logic        out_ack;
    logic        out_req;
    result_t     out_result;
    axi_addr_t   m_axi_araddr;
    axi_len_t    m_axi_arlen;
    logic        m_axi_arvalid;
    logic        m_axi_arready;
    logic [63:0] m_axi_rdata;
    logic        m_axi_rvalid;
    logic        m_axi_rready;
    logic        m_axi_rlast;
    logic [3:0]  gap_odds;

    axi_addr_t   run_src;
    axi_addr_t   run_dqm;
    axi_addr_t   exp_addr;
    axi_len_t    exp_len;
    int          blk_total;
    int          ar_cnt;
    int          res_cnt;
    int          errors;
    int          ack_wait;
    int          max_delay;
    integer      seed;

    fetch_top i_dut (
        .clk, .rst_n, .m_axi_araddr, .m_axi_arlen, .m_axi_arvalid, .m_axi_arready,
        .m_axi_rdata, .m_axi_rvalid, .m_axi_rready, .m_axi_rlast, .start_pulse,
        .source_address, .dqm_address, .w1, .h1, .out_result, .out_req, .out_ack
    );

    axi_rd_mem_model i_mem (
        .clk, .rst_n,
        .araddr   (m_axi_araddr),
        .arlen    (m_axi_arlen),
        .arvalid  (m_axi_arvalid),
        .arready  (m_axi_arready),
        .rdata    (m_axi_rdata),
        .rvalid   (m_axi_rvalid),
        .rready   (m_axi_rready),
        .rlast    (m_axi_rlast),
        .gap_odds
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("FAIL %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic stop_on_timeout(string what);
        $display("Timeout while waiting for %s", what);
        $display("Errors: %0d", errors + 1);
        $display("Some tests failed");
        $finish;
    endtask

    function automatic int draw_delay(int max);
        if (max == 0) return 0;
        return ($random(seed) & 32'h7fffffff) % (max + 1);
    endfunction

    // Scale entry (k mod 8) * 3 + c, times the pixel sum of beat c
    function automatic result_t expected_result(int k, axi_addr_t src, axi_addr_t dqm);
        logic [31:0] acc;
        logic [63:0] word;
        logic [15:0] scale;
        logic [10:0] sum;
        logic [11:0] idx;
        int          e;
        acc = '0;
        for (int c = 0; c < `FETCH_BLK_BEATS; c++) begin
            e     = (k % `FETCH_SCALE_SETS) * 3 + c;
            idx   = 12'((dqm >> 3) + 64'(e / 4));
            word  = i_mem.mem[idx];
            scale = word[16 * (e % 4) +: 16];
            idx   = 12'((src >> 3) + 64'(k * (`FETCH_BLK_STRIDE / 8) + c));
            word  = i_mem.mem[idx];
            sum   = '0;
            for (int b = 0; b < 8; b++) begin
                sum = sum + 11'(word[8 * b +: 8]);
            end
            acc = acc + 32'(sum) * 32'(scale);
        end
        return result_t'(acc >> `FETCH_SCALE_SHIFT);
    endfunction

    //------------------------------------------------
    // AR address sequence
    //------------------------------------------------
    always @(posedge clk) begin
        if (rst_n && m_axi_arvalid && m_axi_arready) begin
            if (ar_cnt == 0) begin
                exp_addr = run_dqm;
                exp_len  = axi_len_t'(`FETCH_DQM_BEATS - 1);
            end else begin
                exp_addr = run_src + axi_addr_t'((ar_cnt - 1) * `FETCH_BLK_STRIDE);
                exp_len  = axi_len_t'(`FETCH_BLK_BEATS - 1);
            end
            check_value("m_axi_araddr", m_axi_araddr, exp_addr);
            check_value("m_axi_arlen", 64'(m_axi_arlen), 64'(exp_len));
            ar_cnt++;
        end
    end

    //------------------------------------------------
    // Result compare and out_ack with random delay
    //------------------------------------------------
    always @(negedge clk) begin
        if (rst_n && (out_req != out_ack)) begin
            if (ack_wait > 0) begin
                ack_wait--;
            end else if (out_req) begin
                assert (res_cnt < blk_total) else begin
                    errors++;
                    $display("Extra result after all %0d blocks", blk_total);
                end
                if (res_cnt < blk_total) begin
                    check_value("out_result", 64'(out_result),
                                64'(expected_result(res_cnt, run_src, run_dqm)));
                end
                res_cnt++;
                out_ack  = 1'b1;
                ack_wait = draw_delay(max_delay);
            end else begin
                out_ack  = 1'b0;
                ack_wait = draw_delay(max_delay);
            end
        end
    end

    task automatic run_blocks(axi_addr_t src, axi_addr_t dqm, int w, int h, int gap, int dly);
        int t;
        @(negedge clk);
        run_src        = src;
        run_dqm        = dqm;
        blk_total      = (w + 1) * (h + 1);
        ar_cnt         = 0;
        res_cnt        = 0;
        max_delay      = dly;
        gap_odds       = 4'(gap);
        source_address = src;
        dqm_address    = dqm;
        w1             = blk_dim_t'(w);
        h1             = blk_dim_t'(h);
        start_pulse    = 1'b1;
        @(negedge clk);
        start_pulse = 1'b0;
        for (t = 0; t < 2000 + blk_total * 400 && res_cnt < blk_total; t++) begin
            @(posedge clk);
        end
        if (res_cnt < blk_total) stop_on_timeout("block results");
        for (t = 0; t < 200 && (out_req || out_ack); t++) begin
            @(posedge clk);
        end
        if (out_req || out_ack) stop_on_timeout("out_req and out_ack to drop");
        // Quiet window to catch a duplicate result
        for (t = 0; t < 64; t++) begin
            @(posedge clk);
        end
        check_value("ar_count", 64'(ar_cnt), 64'(blk_total + 1));
        check_value("result_count", 64'(res_cnt), 64'(blk_total));
    endtask

    initial begin
        seed           = 32'h917e26fb;
        errors         = 0;
        ack_wait       = 0;
        max_delay      = 0;
        blk_total      = 0;
        ar_cnt         = 0;
        res_cnt        = 0;
        run_src        = '0;
        run_dqm        = '0;
        rst_n          = 1'b0;
        start_pulse    = 1'b0;
        source_address = '0;
        dqm_address    = '0;
        w1             = '0;
        h1             = '0;
        out_ack        = 1'b0;
        gap_odds       = '0;
        for (int i = 0; i < 4096; i++) begin
            i_mem.mem[i] = {$random(seed), $random(seed)};
        end
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_value("m_axi_arvalid", 64'(m_axi_arvalid), 64'h0);
        check_value("m_axi_rready", 64'(m_axi_rready), 64'h0);
        check_value("out_req", 64'(out_req), 64'h0);

        // Single block, then a full grid, then a new job under heavy stalls
        run_blocks(64'h0000_0400, 64'h0000_0080, 0, 0, 0, 0);
        run_blocks(64'h0000_1000, 64'h0000_0100, 3, 2, 4, 3);
        run_blocks(64'h0000_0001_0000_4000, 64'h0000_0001_0000_7f00, 4, 1, 12, 40);

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
